// File: hw/crc_consts.svh
/*
 * CRC accelerator constants
 * Register word offsets, reset values, CTRL field positions and the
 * data word width shared by the RTL and the testbench.
 */

`ifndef CRC_CONSTS_SVH
`define CRC_CONSTS_SVH

// ---------------------------------------------------------------------------
// register map, word offsets
// ---------------------------------------------------------------------------
`define CRC_ADDR_DATA       2'd0            // seed or data in, crc out
`define CRC_ADDR_GPOLY      2'd1            // generator polynomial
`define CRC_ADDR_CTRL       2'd2            // mode control
// offset 3 is unmapped and reads as zero

// ---------------------------------------------------------------------------
// reset values
// ---------------------------------------------------------------------------
`define CRC_GPOLY_RESET     32'h0000_1021   // ccitt polynomial
`define CRC_STATE_RESET     32'hFFFF_FFFF   // remainder after reset

// ---------------------------------------------------------------------------
// CTRL field positions
// ---------------------------------------------------------------------------
`define CRC_TOT_MSB         31              // write transpose
`define CRC_TOT_LSB         30
`define CRC_TOTR_MSB        29              // read transpose
`define CRC_TOTR_LSB        28
`define CRC_FXOR_BIT        26              // complement on read
`define CRC_WAS_BIT         25              // data write loads the seed
`define CRC_TCRC_BIT        24              // 1 selects 32-bit crc

// ---------------------------------------------------------------------------
// data path width
// ---------------------------------------------------------------------------
`define CRC_WORD_BITS       32

`endif

// File: hw/crc_reg_pkg.sv
/*
 * CRC register map types
 * Register offset and the transpose modes held in CTRL.
 */

package crc_reg_pkg;

  // word offset into the register block
  typedef logic [1:0] reg_addr_t;

  // ---------------------------------------------------------------------------
  // transpose modes for TOT (writes) and TOTR (reads)
  // ---------------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    ORDER_NONE          = 2'd0,   // word passes unchanged
    ORDER_BITS_IN_BYTES = 2'd1,   // bits reversed inside each byte
    ORDER_ALL_BITS      = 2'd2,   // full 32-bit reversal
    ORDER_BYTES         = 2'd3    // byte order reversed
  } transpose_t;

endpackage

// File: hw/crc_data_pkg.sv
/*
 * CRC data path types
 * Bus word, CRC remainder and the width select.
 */

`include "crc_consts.svh"

package crc_data_pkg;

  // bus or data word
  typedef logic [`CRC_WORD_BITS-1:0] crc_word_t;

  // crc remainder, upper half zero in 16-bit mode
  typedef logic [`CRC_WORD_BITS-1:0] crc_state_t;

  // 1 = 32-bit crc, 0 = 16-bit crc
  typedef logic crc_width_t;

endpackage

// File: hw/crc_bit_order.sv
/*
 * Transpose network
 * Reorders a 32-bit word by one of four transpose modes, used on the
 * write path and again on the read path.
 */

module crc_bit_order
(
  input  crc_data_pkg::crc_word_t  word_in,
  input  crc_reg_pkg::transpose_t  order,
  output crc_data_pkg::crc_word_t  word_out
);

  always_comb
  begin
    word_out = word_in;
    case (order)
      crc_reg_pkg::ORDER_NONE:
        word_out = word_in;
      crc_reg_pkg::ORDER_BITS_IN_BYTES:
        for (int b = 0; b < 4; b++)
          for (int i = 0; i < 8; i++)
            word_out[8*b + i] = word_in[8*b + 7 - i];   // mirror within byte b
      crc_reg_pkg::ORDER_ALL_BITS:
        for (int i = 0; i < 32; i++)
          word_out[i] = word_in[31 - i];
      crc_reg_pkg::ORDER_BYTES:
        for (int b = 0; b < 4; b++)
          word_out[8*b +: 8] = word_in[8*(3 - b) +: 8];  // bits kept inside each byte
      default:
        word_out = word_in;
    endcase
  end

endmodule

// File: hw/crc_regs.sv
/*
 * CRC register block
 * Holds GPOLY and the CTRL fields, turns DATA writes into seed or data
 * strobes according to WAS, and registers read data one cycle after rd.
 */

`include "crc_consts.svh"

module crc_regs
(
  input  logic                      m,
  input  logic                      reset,
  input  logic                      wr,
  input  logic                      rd,
  input  crc_reg_pkg::reg_addr_t    addr,
  input  crc_data_pkg::crc_word_t   wdata,
  input  crc_data_pkg::crc_word_t   read_word,    // formatted crc for DATA reads
  output crc_data_pkg::crc_word_t   rdata,
  output logic                      rdata_valid,
  output crc_data_pkg::crc_word_t   gpoly,
  output crc_reg_pkg::transpose_t   ctrl_tot,
  output crc_reg_pkg::transpose_t   ctrl_totr,
  output logic                      ctrl_fxor,
  output logic                      ctrl_was,
  output crc_data_pkg::crc_width_t  ctrl_tcrc,
  output logic                      data_load,
  output logic                      seed_load
);

  logic                     data_wr;       // write hits DATA
  crc_data_pkg::crc_word_t  ctrl_word;     // CTRL as seen on the bus
  crc_data_pkg::crc_word_t  read_mux;

  // ---------------------------------------------------------------------------
  // write decode
  // ---------------------------------------------------------------------------
  assign data_wr   = wr && (addr == `CRC_ADDR_DATA);
  assign data_load = data_wr && !ctrl_was;
  assign seed_load = data_wr && ctrl_was;

  always_ff @(posedge m)
  begin
    if (reset)
    begin
      gpoly     <= `CRC_GPOLY_RESET;
      ctrl_tot  <= crc_reg_pkg::ORDER_NONE;
      ctrl_totr <= crc_reg_pkg::ORDER_NONE;
      ctrl_fxor <= 1'b0;
      ctrl_was  <= 1'b0;
      ctrl_tcrc <= 1'b0;
    end
    else if (wr)
    begin
      if (addr == `CRC_ADDR_GPOLY)
        gpoly <= wdata;
      if (addr == `CRC_ADDR_CTRL)
      begin
        ctrl_tot  <= crc_reg_pkg::transpose_t'(wdata[`CRC_TOT_MSB:`CRC_TOT_LSB]);
        ctrl_totr <= crc_reg_pkg::transpose_t'(wdata[`CRC_TOTR_MSB:`CRC_TOTR_LSB]);
        ctrl_fxor <= wdata[`CRC_FXOR_BIT];
        ctrl_was  <= wdata[`CRC_WAS_BIT];
        ctrl_tcrc <= wdata[`CRC_TCRC_BIT];   // undefined bits are dropped
      end
    end
  end

  // ---------------------------------------------------------------------------
  // read path
  // ---------------------------------------------------------------------------
  always_comb
  begin
    ctrl_word                                = '0;
    ctrl_word[`CRC_TOT_MSB:`CRC_TOT_LSB]     = ctrl_tot;
    ctrl_word[`CRC_TOTR_MSB:`CRC_TOTR_LSB]   = ctrl_totr;
    ctrl_word[`CRC_FXOR_BIT]                 = ctrl_fxor;
    ctrl_word[`CRC_WAS_BIT]                  = ctrl_was;
    ctrl_word[`CRC_TCRC_BIT]                 = ctrl_tcrc;
  end

  always_comb
  begin
    case (addr)
      `CRC_ADDR_DATA:  read_mux = read_word;
      `CRC_ADDR_GPOLY: read_mux = gpoly;
      `CRC_ADDR_CTRL:  read_mux = ctrl_word;
      default:         read_mux = '0;       // unmapped offset
    endcase
  end

  always_ff @(posedge m)
  begin
    if (reset)
    begin
      rdata       <= '0;
      rdata_valid <= 1'b0;
    end
    else
    begin
      rdata_valid <= rd;
      if (rd)
        rdata <= read_mux;                   // held until the next read
    end
  end

  // the bus never issues a read and a write in the same cycle
  a_no_wr_rd: assert property (@(posedge m) disable iff (reset) !(wr && rd));

endmodule

// File: hw/crc_engine.sv
/*
 * CRC engine
 * Keeps the CRC remainder, loads a seed, or folds a full 32-bit data
 * word through the generator polynomial in a single cycle.
 */

`include "crc_consts.svh"

module crc_engine
(
  input  logic                      m,
  input  logic                      reset,
  input  crc_data_pkg::crc_word_t   order_word,   // transposed write data
  input  crc_data_pkg::crc_word_t   gpoly,
  input  crc_data_pkg::crc_width_t  width,
  input  logic                      data_load,
  input  logic                      seed_load,
  output crc_data_pkg::crc_state_t  state
);

  crc_data_pkg::crc_state_t  acc_32;   // 32-bit fold
  logic [15:0]               acc_16;   // 16-bit fold
  crc_data_pkg::crc_state_t  fold;
  crc_data_pkg::crc_state_t  seed;

  // ---------------------------------------------------------------------------
  // shift-in-then-reduce, msb of the data word first
  // ---------------------------------------------------------------------------
  always_comb
  begin
    acc_32 = state;
    acc_16 = state[15:0];
    for (int i = `CRC_WORD_BITS - 1; i >= 0; i--)
    begin
      if (acc_32[31])
        acc_32 = {acc_32[30:0], order_word[i]} ^ gpoly;
      else
        acc_32 = {acc_32[30:0], order_word[i]};
      if (acc_16[15])
        acc_16 = {acc_16[14:0], order_word[i]} ^ gpoly[15:0];
      else
        acc_16 = {acc_16[14:0], order_word[i]};
    end
  end

  assign fold = width ? acc_32 : {16'h0000, acc_16};
  assign seed = width ? order_word : {16'h0000, order_word[15:0]};

  // ---------------------------------------------------------------------------
  // remainder register
  // ---------------------------------------------------------------------------
  always_ff @(posedge m)
  begin
    if (reset)
      state <= `CRC_STATE_RESET;
    else if (seed_load)
      state <= seed;
    else if (data_load)
      state <= fold;
  end

  // regs decode the two strobes from one DATA write, only one may fire
  a_one_load: assert property (@(posedge m) disable iff (reset)
    !(data_load && seed_load));

  // a load in 16-bit mode leaves the upper half clear
  a_upper_clear: assert property (@(posedge m) disable iff (reset)
    ((data_load || seed_load) && !width) |=> (state[31:16] == 16'h0000));

endmodule

// File: hw/crc_readout.sv
/*
 * CRC readback formatter
 * Complements the active CRC width when FXOR is set, then applies the
 * read transpose selected by TOTR.
 */

module crc_readout
(
  input  crc_data_pkg::crc_state_t  state,
  input  crc_data_pkg::crc_width_t  width,
  input  logic                      fxor,
  input  crc_reg_pkg::transpose_t   order,
  output crc_data_pkg::crc_word_t   read_word
);

  crc_data_pkg::crc_word_t  inv_mask;   // bits touched by the complement
  crc_data_pkg::crc_word_t  inv_word;

  // ---------------------------------------------------------------------------
  // complement before transposition
  // ---------------------------------------------------------------------------
  assign inv_mask = width ? 32'hFFFF_FFFF : 32'h0000_FFFF;
  assign inv_word = fxor ? (state ^ inv_mask) : state;

  // ---------------------------------------------------------------------------
  // read transpose
  // ---------------------------------------------------------------------------
  crc_bit_order u_read_order
  (
    .word_in  (inv_word),
    .order    (order),
    .word_out (read_word)
  );

endmodule

// File: hw/crc_unit.sv
/*
 * CRC accelerator top level
 * Word-addressed DATA, GPOLY and CTRL registers around a 16/32-bit
 * CRC engine with write and read transposition.
 */

module crc_unit
(
  input  logic                     m,
  input  logic                     reset,
  input  logic                     wr,           // one-cycle write strobe
  input  logic                     rd,           // one-cycle read strobe
  input  crc_reg_pkg::reg_addr_t   addr,
  input  crc_data_pkg::crc_word_t  wdata,
  output crc_data_pkg::crc_word_t  rdata,
  output logic                     rdata_valid
);

  crc_data_pkg::crc_word_t   gpoly;
  crc_reg_pkg::transpose_t   ctrl_tot;
  crc_reg_pkg::transpose_t   ctrl_totr;
  logic                      ctrl_fxor;
  logic                      ctrl_was;
  crc_data_pkg::crc_width_t  ctrl_tcrc;
  logic                      data_load;
  logic                      seed_load;
  crc_data_pkg::crc_word_t   order_word;   // write data after TOT
  crc_data_pkg::crc_state_t  state;
  crc_data_pkg::crc_word_t   read_word;    // crc after FXOR and TOTR

  // ---------------------------------------------------------------------------
  // register block
  // ---------------------------------------------------------------------------
  crc_regs u_regs
  (
    .m           (m),
    .reset       (reset),
    .wr          (wr),
    .rd          (rd),
    .addr        (addr),
    .wdata       (wdata),
    .read_word   (read_word),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .gpoly       (gpoly),
    .ctrl_tot    (ctrl_tot),
    .ctrl_totr   (ctrl_totr),
    .ctrl_fxor   (ctrl_fxor),
    .ctrl_was    (ctrl_was),
    .ctrl_tcrc   (ctrl_tcrc),
    .data_load   (data_load),
    .seed_load   (seed_load)
  );

  // ---------------------------------------------------------------------------
  // data path
  // ---------------------------------------------------------------------------
  crc_bit_order u_write_order
  (
    .word_in  (wdata),
    .order    (ctrl_tot),
    .word_out (order_word)
  );

  crc_engine u_engine
  (
    .m          (m),
    .reset      (reset),
    .order_word (order_word),
    .gpoly      (gpoly),
    .width      (ctrl_tcrc),
    .data_load  (data_load),
    .seed_load  (seed_load),
    .state      (state)
  );

  crc_readout u_readout
  (
    .state     (state),
    .width     (ctrl_tcrc),
    .fxor      (ctrl_fxor),
    .order     (ctrl_totr),
    .read_word (read_word)
  );

endmodule

// File: testbench/crc_tb_model.svh
/*
 * CRC reference model
 * Transpose, CRC update, seed and readback rules used to predict the DUT.
 */

`ifndef CRC_TB_MODEL_SVH
`define CRC_TB_MODEL_SVH

`include "crc_consts.svh"

function automatic crc_data_pkg::crc_word_t swap_bytes(input crc_data_pkg::crc_word_t w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic crc_data_pkg::crc_word_t mirror_each_byte(input crc_data_pkg::crc_word_t w);
  crc_data_pkg::crc_word_t r;
  for (int i = 0; i < 32; i++)
    r[i] = w[(i / 8) * 8 + 7 - (i % 8)];
  return r;
endfunction

function automatic crc_data_pkg::crc_word_t transpose_word(input crc_data_pkg::crc_word_t w,
                                                           input crc_reg_pkg::transpose_t order);
  crc_data_pkg::crc_word_t r;
  case (order)
    crc_reg_pkg::ORDER_BITS_IN_BYTES: r = mirror_each_byte(w);
    crc_reg_pkg::ORDER_ALL_BITS:      r = swap_bytes(mirror_each_byte(w));   // full reversal
    crc_reg_pkg::ORDER_BYTES:         r = swap_bytes(w);
    default:                          r = w;
  endcase
  return r;
endfunction

// shift each data bit in from the right, reduce when the old top bit was set
function automatic crc_data_pkg::crc_state_t crc_fold(input crc_data_pkg::crc_state_t st,
                                                      input crc_data_pkg::crc_word_t data,
                                                      input crc_data_pkg::crc_word_t poly,
                                                      input crc_data_pkg::crc_width_t wide);
  crc_data_pkg::crc_word_t mask;
  int                      top;
  logic                    carry;
  mask = wide ? 32'hFFFF_FFFF : 32'h0000_FFFF;
  top  = wide ? 31 : 15;
  st   = st & mask;
  for (int i = 31; i >= 0; i--)
  begin
    carry = st[top];
    st    = {st[30:0], data[i]} & mask;
    if (carry)
      st = st ^ (poly & mask);
  end
  return st;
endfunction

function automatic crc_data_pkg::crc_word_t crc_readback(input crc_data_pkg::crc_state_t st,
                                                         input crc_data_pkg::crc_width_t wide,
                                                         input logic fxor,
                                                         input crc_reg_pkg::transpose_t order);
  crc_data_pkg::crc_word_t shown;
  shown = st;
  if (fxor && wide)
    shown = ~shown;
  else if (fxor)
    shown[15:0] = ~shown[15:0];   // only the active half
  return transpose_word(shown, order);
endfunction

function automatic crc_data_pkg::crc_word_t ctrl_defined_mask();
  crc_data_pkg::crc_word_t mask;
  mask                                 = '0;
  mask[`CRC_TOT_MSB:`CRC_TOT_LSB]      = 2'b11;
  mask[`CRC_TOTR_MSB:`CRC_TOTR_LSB]    = 2'b11;
  mask[`CRC_FXOR_BIT]                  = 1'b1;
  mask[`CRC_WAS_BIT]                   = 1'b1;
  mask[`CRC_TCRC_BIT]                  = 1'b1;
  return mask;
endfunction

`endif

// File: testbench/crc_unit_tb.sv
/*
 * CRC accelerator testbench
 * Random register, seed, data and read traffic checked against a model.
 */

`include "crc_consts.svh"

module crc_unit_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int READ_TIMEOUT = 20;   // cycles

  logic                     m = 1'b0;
  logic                     reset;
  logic                     wr;
  logic                     rd;
  crc_reg_pkg::reg_addr_t   addr;
  crc_data_pkg::crc_word_t  wdata;
  crc_data_pkg::crc_word_t  rdata;
  logic                     rdata_valid;

  crc_data_pkg::crc_word_t  model_gpoly;
  crc_data_pkg::crc_word_t  model_ctrl;    // defined bits only
  crc_data_pkg::crc_state_t model_state;
  int                       read_latency;

  `include "crc_tb_model.svh"

  crc_unit UUT
  (
    .m           (m),
    .reset       (reset),
    .wr          (wr),
    .rd          (rd),
    .addr        (addr),
    .wdata       (wdata),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  always #5 m = ~m;

  // --------------------------------------------------------------------------
  // error reporting and compares
  // --------------------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(input string name, input crc_data_pkg::crc_word_t expected,
                            input crc_data_pkg::crc_word_t actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED at %0t: %s expected 0x%08h got 0x%08h",
                         $time, name, expected, actual));
  endtask

  task automatic check_crc(input string name, input crc_data_pkg::crc_word_t expected,
                           input crc_data_pkg::crc_word_t actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED at %0t: %s expected crc 0x%08h got 0x%08h (ctrl 0x%08h)",
                         $time, name, expected, actual, model_ctrl));
  endtask

  // --------------------------------------------------------------------------
  // bus tasks entered and left just after a falling edge
  // --------------------------------------------------------------------------
  task automatic write_reg(input crc_reg_pkg::reg_addr_t a, input crc_data_pkg::crc_word_t d);
    crc_data_pkg::crc_word_t ord;
    addr  = a;
    wdata = d;
    wr    = 1'b1;
    @(negedge m);
    wr    = 1'b0;
    ord   = transpose_word(d, crc_reg_pkg::transpose_t'(model_ctrl[`CRC_TOT_MSB:`CRC_TOT_LSB]));
    if (a == `CRC_ADDR_DATA && model_ctrl[`CRC_WAS_BIT])
      model_state = model_ctrl[`CRC_TCRC_BIT] ? ord : (ord & 32'h0000_FFFF);   // seed
    else if (a == `CRC_ADDR_DATA)
      model_state = crc_fold(model_state, ord, model_gpoly, model_ctrl[`CRC_TCRC_BIT]);
    else if (a == `CRC_ADDR_GPOLY)
      model_gpoly = d;
    else if (a == `CRC_ADDR_CTRL)
      model_ctrl = d & ctrl_defined_mask();
  endtask

  task automatic read_reg(input crc_reg_pkg::reg_addr_t a, output crc_data_pkg::crc_word_t value);
    int waited;
    addr   = a;
    rd     = 1'b1;
    @(negedge m);
    rd     = 1'b0;
    waited = 1;
    while (rdata_valid !== 1'b1)
    begin
      if (waited >= READ_TIMEOUT)
        fail_run($sformatf("timeout: no rdata_valid %0d cycles after a read", waited));
      @(negedge m);
      waited++;
    end
    value        = rdata;
    read_latency = waited;
  endtask

  function automatic crc_data_pkg::crc_word_t expected_read(input crc_reg_pkg::reg_addr_t a);
    if (a == `CRC_ADDR_DATA)
      return crc_readback(model_state, model_ctrl[`CRC_TCRC_BIT], model_ctrl[`CRC_FXOR_BIT],
                          crc_reg_pkg::transpose_t'(model_ctrl[`CRC_TOTR_MSB:`CRC_TOTR_LSB]));
    else if (a == `CRC_ADDR_GPOLY)
      return model_gpoly;
    else if (a == `CRC_ADDR_CTRL)
      return model_ctrl;
    return '0;   // unmapped offset
  endfunction

  task automatic read_check(input crc_reg_pkg::reg_addr_t a, output crc_data_pkg::crc_word_t got);
    crc_data_pkg::crc_word_t expected;
    expected = expected_read(a);
    read_reg(a, got);
    if (a == `CRC_ADDR_DATA)
      check_crc("rdata (DATA)", expected, got);
    else
      check_word($sformatf("rdata (offset %0d)", a), expected, got);
  endtask

  task automatic check_valid_pulse();
    if (read_latency != 1)
      fail_run("rdata_valid did not rise exactly one cycle after rd");
    @(negedge m);
    if (rdata_valid !== 1'b0)
      fail_run("rdata_valid stayed high for more than one cycle");
  endtask

  task automatic write_ctrl_random(input crc_data_pkg::crc_width_t wide, input logic was);
    crc_data_pkg::crc_word_t w;
    w                = $urandom;
    w[`CRC_TCRC_BIT] = wide;
    w[`CRC_WAS_BIT]  = was;
    write_reg(`CRC_ADDR_CTRL, w);
  endtask

  // --------------------------------------------------------------------------
  // seed, fold and readback rounds in one width
  // --------------------------------------------------------------------------
  task automatic crc_sequence(input crc_data_pkg::crc_width_t wide, input int rounds);
    crc_data_pkg::crc_word_t got;
    crc_data_pkg::crc_word_t w;
    int                      n_data;
    for (int r = 0; r < rounds; r++)
    begin
      write_ctrl_random(wide, 1'b1);           // seed under random TOT
      write_reg(`CRC_ADDR_DATA, $urandom);
      write_reg(`CRC_ADDR_GPOLY, $urandom);
      write_ctrl_random(wide, 1'b0);
      n_data = $urandom_range(6, 1);
      for (int k = 0; k < n_data; k++)
        write_reg(`CRC_ADDR_DATA, $urandom);
      for (int k = 0; k < 3; k++)
      begin
        write_ctrl_random(wide, 1'b0);         // new TOTR and FXOR
        read_check(`CRC_ADDR_DATA, got);
      end
      if (!wide)
      begin
        w                 = $urandom;
        w                 = w & (32'h1 << `CRC_FXOR_BIT);   // TOTR none and random FXOR
        write_reg(`CRC_ADDR_CTRL, w);
        read_check(`CRC_ADDR_DATA, got);
      end
    end
  endtask

  task automatic random_mix(input int ops);
    crc_data_pkg::crc_word_t got;
    crc_data_pkg::crc_word_t rnd;
    int                      pick;
    for (int k = 0; k < ops; k++)
    begin
      pick = $urandom_range(9, 0);
      rnd  = $urandom;
      case (pick)
        0:       write_reg(`CRC_ADDR_GPOLY, rnd);
        1, 2:    write_reg(`CRC_ADDR_CTRL, rnd);     // width, WAS and transposes at once
        3, 4, 5: write_reg(`CRC_ADDR_DATA, rnd);
        6, 7, 8: read_check(`CRC_ADDR_DATA, got);
        default: read_check(rnd[1:0], got);
      endcase
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    crc_data_pkg::crc_word_t got;
    void'($urandom(23216));
    reset       = 1'b1;
    wr          = 1'b0;
    rd          = 1'b0;
    addr        = '0;
    wdata       = '0;
    model_gpoly = `CRC_GPOLY_RESET;
    model_ctrl  = '0;
    model_state = `CRC_STATE_RESET;
    repeat (3) @(negedge m);
    reset = 1'b0;

    check_word("rdata after reset", 32'h0, rdata);
    if (rdata_valid !== 1'b0)
      fail_run("rdata_valid is high after reset");
    read_reg(`CRC_ADDR_GPOLY, got);
    check_word("GPOLY after reset", 32'h0000_1021, got);
    check_valid_pulse();
    read_reg(`CRC_ADDR_CTRL, got);
    check_word("CTRL after reset", 32'h0, got);
    check_valid_pulse();
    read_reg(`CRC_ADDR_DATA, got);
    check_crc("DATA after reset", 32'hFFFF_FFFF, got);
    check_valid_pulse();

    for (int k = 0; k < 20; k++)
    begin
      write_reg(`CRC_ADDR_GPOLY, $urandom);
      read_check(`CRC_ADDR_GPOLY, got);
      write_reg(`CRC_ADDR_CTRL, $urandom);
      read_check(`CRC_ADDR_CTRL, got);
    end
    read_reg(2'd3, got);
    check_word("rdata (offset 3)", 32'h0, got);

    crc_sequence(1'b1, 30);
    crc_sequence(1'b0, 30);
    for (int s = 0; s < 5; s++)
      random_mix(200);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+hw
+incdir+testbench
hw/crc_reg_pkg.sv
hw/crc_data_pkg.sv
hw/crc_bit_order.sv
hw/crc_regs.sv
hw/crc_engine.sv
hw/crc_readout.sv
hw/crc_unit.sv
testbench/crc_unit_tb.sv

// File: Makefile
TOP := crc_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
